// ==== design/fsync_pkg.sv ====
/*
  Shared widths and word formats of the barrier synchronization node.
  One-dimensional node with two ports only. The level taken from a mask
  fits LEVEL_W bits, so AGGR_W must not exceed 2**LEVEL_W.
*/

package fsync_pkg;

  // ####################
  // Widths and constants
  // ####################

  localparam int unsigned N_PORTS = 2;
  localparam int unsigned AGGR_W  = 8;
  localparam int unsigned LEVEL_W = 3;
  localparam int unsigned ID_W    = 4;
  localparam int unsigned SRC_W   = 4;

  localparam logic [1:0] SD_MASK = 2'b11;  // Side tag on forwarded sources.

  typedef logic [LEVEL_W-1:0] level_t;

  // ####################
  // Word formats
  // ####################

  typedef struct packed {
    logic              sync;  // Single-cycle strobe.
    logic [AGGR_W-1:0] aggr;
    logic [ID_W-1:0]   id;
    logic [SRC_W-1:0]  src;
  } fsync_req_t;

  typedef struct packed {
    logic             wake;
    logic [SRC_W-1:0] dst;
    logic             error;
  } fsync_rsp_t;

  typedef struct packed {
    logic               sync;
    logic [AGGR_W-1:0]  aggr;
    logic [ID_W-1:0]    id;
    logic [SRC_W+1:0]   src;  // Source followed by side tag.
  } fsync_fwd_t;

  // Check order from a port FSM to the register file.
  typedef struct packed {
    logic            check_local;
    logic            check_remote;
    level_t          level;
    logic [ID_W-1:0] id;
  } rf_check_t;

  typedef struct packed {
    logic present;
    logic id_err;
    logic sig_err;
  } rf_result_t;

  typedef enum logic [1:0] {
    IDLE,
    ROOT,
    AGGR
  } port_state_e;

endpackage

// ==== design/fsync_fifo.sv ====
/*
  Show-ahead FIFO. The head word is on data_o while empty_o is low.
  No back-pressure. A push when full or a pop when empty is dropped and
  raises misuse_o for that cycle. Any DEPTH of 1 or more.
*/

`timescale 1ns/1ps

module fsync_fifo #(
  parameter int unsigned DEPTH  = 2,
  parameter type         elem_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  elem_t data_i,
  input  logic  pop_i,
  output elem_t data_o,
  output logic  empty_o,
  output logic  misuse_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  elem_t            mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full, push_ok, pop_ok;

  assign empty_o  = (count_q == '0);
  assign full     = (count_q == CNT_W'(DEPTH));
  assign push_ok  = push_i & ~full;
  assign pop_ok   = pop_i & ~empty_o;
  assign misuse_o = (push_i & full) | (pop_i & empty_o);
  assign data_o   = mem_q[rd_ptr_q];  // Show-ahead head.

  always_ff @(posedge clk_i) begin
    if (push_ok) mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap at DEPTH, which need not be a power of two.
      if (push_ok) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop_ok)  rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither.
      endcase
    end
  end

endmodule

// ==== design/fsync_barrier_rf.sv ====
/*
  Barrier register file with a local and a remote bank, both direct
  mapped by level with N_LOCAL_REGS entries. Checks of both ports are
  applied in port order within a cycle. Results appear one cycle after
  the check. A level of N_LOCAL_REGS or more is a sig_err.
*/

`timescale 1ns/1ps

module fsync_barrier_rf #(
  parameter int unsigned N_LOCAL_REGS = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  fsync_pkg::rf_check_t   check_i  [fsync_pkg::N_PORTS],
  output fsync_pkg::rf_result_t  result_o [fsync_pkg::N_PORTS]
);

  localparam int unsigned N_BANKS = 2;  // 0 is local, 1 is remote.

  logic [N_LOCAL_REGS-1:0]      valid_q [N_BANKS];
  logic [N_LOCAL_REGS-1:0]      valid_d [N_BANKS];
  logic [fsync_pkg::ID_W-1:0]   id_q    [N_BANKS][N_LOCAL_REGS];
  logic [fsync_pkg::ID_W-1:0]   id_d    [N_BANKS][N_LOCAL_REGS];
  fsync_pkg::rf_result_t        res_d   [fsync_pkg::N_PORTS];

  // ####################
  // Check logic
  // ####################

  always_comb begin
    int unsigned bank;
    int unsigned idx;
    valid_d = valid_q;
    id_d    = id_q;
    bank    = 0;
    idx     = 0;
    for (int p = 0; p < fsync_pkg::N_PORTS; p++) begin
      res_d[p] = '0;
      // Port 1 sees the state left behind by port 0.
      if (check_i[p].check_local | check_i[p].check_remote) begin
        bank = check_i[p].check_local ? 0 : 1;
        idx  = 32'(check_i[p].level);
        if (idx >= N_LOCAL_REGS) begin
          res_d[p].sig_err = 1'b1;  // No entry for this level.
        end else if (!valid_d[bank][idx]) begin
          valid_d[bank][idx] = 1'b1;  // First arrival.
          id_d[bank][idx]    = check_i[p].id;
        end else if (id_d[bank][idx] == check_i[p].id) begin
          valid_d[bank][idx] = 1'b0;  // Barrier complete.
          res_d[p].present   = 1'b1;
        end else begin
          res_d[p].id_err = 1'b1;
        end
      end
    end
  end

  // ####################
  // Storage
  // ####################

  always_ff @(posedge clk_i) begin
    id_q <= id_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int b = 0; b < N_BANKS; b++) begin
        valid_q[b] <= '0;
      end
      for (int p = 0; p < fsync_pkg::N_PORTS; p++) begin
        result_o[p] <= '0;
      end
    end else begin
      valid_q  <= valid_d;
      result_o <= res_d;  // Valid in the FSM's ROOT or AGGR cycle.
    end
  end

endmodule

// ==== design/fsync_port_ctrl.sv ====
/*
  Per-port control FSM. A request strobe is taken only in IDLE with
  root_i or local_i high; anything else is ignored. The FSM spends one
  cycle in ROOT or AGGR, then returns to IDLE, so a port takes a new
  request every two cycles.
*/

`timescale 1ns/1ps

module fsync_port_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  fsync_pkg::fsync_req_t req_i,
  input  logic                  local_i,
  input  logic                  root_i,
  output fsync_pkg::rf_check_t  check_o,
  input  fsync_pkg::rf_result_t result_i,
  output logic                  push_local_o,
  output fsync_pkg::fsync_rsp_t rsp_o,
  output logic                  push_remote_o,
  output fsync_pkg::fsync_fwd_t fwd_o
);

  fsync_pkg::port_state_e state_q, state_d;
  fsync_pkg::fsync_req_t  req_q;
  fsync_pkg::level_t      level;
  logic                   accept, rf_err;

  // Level is the index of the highest set mask bit.
  always_comb begin
    level = '0;
    for (int j = 0; j < fsync_pkg::AGGR_W; j++) begin
      if (req_i.aggr[j]) level = fsync_pkg::LEVEL_W'(j);
    end
  end

  assign accept = req_i.sync & (state_q == fsync_pkg::IDLE) & (root_i | local_i);

  assign check_o.check_local  = accept & root_i;
  assign check_o.check_remote = accept & ~root_i;
  assign check_o.level        = level;
  assign check_o.id           = req_i.id;

  always_ff @(posedge clk_i) begin
    if (accept) req_q <= req_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) state_q <= fsync_pkg::IDLE;
    else         state_q <= state_d;
  end

  assign rf_err = result_i.id_err | result_i.sig_err;

  // Next state and push rule.
  always_comb begin
    state_d       = state_q;
    push_local_o  = 1'b0;
    push_remote_o = 1'b0;
    unique case (state_q)
      fsync_pkg::IDLE: begin
        if (check_o.check_local)       state_d = fsync_pkg::ROOT;
        else if (check_o.check_remote) state_d = fsync_pkg::AGGR;
      end
      fsync_pkg::ROOT: begin
        state_d      = fsync_pkg::IDLE;
        push_local_o = result_i.present | rf_err;
      end
      fsync_pkg::AGGR: begin
        state_d = fsync_pkg::IDLE;
        if (rf_err) push_local_o  = 1'b1;  // Errors go back locally.
        else        push_remote_o = result_i.present;
      end
      default: state_d = fsync_pkg::IDLE;
    endcase
  end

  // Output words from the registered request.
  assign rsp_o.wake  = 1'b1;
  assign rsp_o.dst   = req_q.src;
  assign rsp_o.error = rf_err;

  assign fwd_o.sync = 1'b1;
  assign fwd_o.aggr = req_q.aggr >> 1;  // One level up.
  assign fwd_o.id   = req_q.id;
  assign fwd_o.src  = {req_q.src, fsync_pkg::SD_MASK};

endmodule

// ==== design/fsync_port.sv ====
/*
  One node port: control FSM with its local and remote output FIFOs.
  detected_error_o is sticky until reset and set by misuse of either FIFO.
*/

`timescale 1ns/1ps

module fsync_port #(
  parameter int unsigned FIFO_DEPTH_L = 2,
  parameter int unsigned FIFO_DEPTH_R = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  fsync_pkg::fsync_req_t req_i,
  input  logic                  local_i,
  input  logic                  root_i,
  output fsync_pkg::rf_check_t  check_o,
  input  fsync_pkg::rf_result_t result_i,
  output logic                  local_empty_o,
  output fsync_pkg::fsync_rsp_t local_rsp_o,
  input  logic                  local_pop_i,
  output logic                  remote_empty_o,
  output fsync_pkg::fsync_fwd_t remote_req_o,
  input  logic                  remote_pop_i,
  output logic                  detected_error_o
);

  fsync_pkg::fsync_rsp_t rsp;
  fsync_pkg::fsync_fwd_t fwd;
  logic push_local, push_remote;
  logic local_misuse, remote_misuse;
  logic error_q;

  fsync_port_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .local_i       (local_i),
    .root_i        (root_i),
    .check_o       (check_o),
    .result_i      (result_i),
    .push_local_o  (push_local),
    .rsp_o         (rsp),
    .push_remote_o (push_remote),
    .fwd_o         (fwd)
  );

  fsync_fifo #(.DEPTH(FIFO_DEPTH_L), .elem_t(fsync_pkg::fsync_rsp_t)) u_local_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .push_i   (push_local),
    .data_i   (rsp),
    .pop_i    (local_pop_i),
    .data_o   (local_rsp_o),
    .empty_o  (local_empty_o),
    .misuse_o (local_misuse)
  );

  fsync_fifo #(.DEPTH(FIFO_DEPTH_R), .elem_t(fsync_pkg::fsync_fwd_t)) u_remote_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .push_i   (push_remote),
    .data_i   (fwd),
    .pop_i    (remote_pop_i),
    .data_o   (remote_req_o),
    .empty_o  (remote_empty_o),
    .misuse_o (remote_misuse)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) error_q <= 1'b0;
    else         error_q <= error_q | local_misuse | remote_misuse;  // Sticky.
  end

  assign detected_error_o = error_q;

endmodule

// ==== design/fsync_cc.sv ====
/*
  Control core of a one-dimensional barrier node with two ports.
  Both ports share one register file. Outputs have no back-pressure,
  so the environment must pop promptly.
*/

`timescale 1ns/1ps

module fsync_cc #(
  parameter int unsigned N_LOCAL_REGS = 4,
  parameter int unsigned FIFO_DEPTH_L = 2,
  parameter int unsigned FIFO_DEPTH_R = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  fsync_pkg::fsync_req_t         req_i            [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::N_PORTS-1:0] local_i,
  input  logic [fsync_pkg::N_PORTS-1:0] root_i,
  output logic [fsync_pkg::N_PORTS-1:0] local_empty_o,
  output fsync_pkg::fsync_rsp_t         local_rsp_o      [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::N_PORTS-1:0] local_pop_i,
  output logic [fsync_pkg::N_PORTS-1:0] remote_empty_o,
  output fsync_pkg::fsync_fwd_t         remote_req_o     [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::N_PORTS-1:0] remote_pop_i,
  output logic [fsync_pkg::N_PORTS-1:0] detected_error_o
);

  fsync_pkg::rf_check_t  check  [fsync_pkg::N_PORTS];
  fsync_pkg::rf_result_t result [fsync_pkg::N_PORTS];

  for (genvar i = 0; i < fsync_pkg::N_PORTS; i++) begin : gen_port
    fsync_port #(.FIFO_DEPTH_L(FIFO_DEPTH_L), .FIFO_DEPTH_R(FIFO_DEPTH_R)) u_port (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .req_i            (req_i[i]),
      .local_i          (local_i[i]),
      .root_i           (root_i[i]),
      .check_o          (check[i]),
      .result_i         (result[i]),
      .local_empty_o    (local_empty_o[i]),
      .local_rsp_o      (local_rsp_o[i]),
      .local_pop_i      (local_pop_i[i]),
      .remote_empty_o   (remote_empty_o[i]),
      .remote_req_o     (remote_req_o[i]),
      .remote_pop_i     (remote_pop_i[i]),
      .detected_error_o (detected_error_o[i])
    );
  end

  // Shared by both ports; port 0 has priority within a cycle.
  fsync_barrier_rf #(.N_LOCAL_REGS(N_LOCAL_REGS)) u_rf (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .check_i  (check),
    .result_o (result)
  );

endmodule

// ==== verif/fsync_cc_assert.sv ====
/*
  Protocol checks for the barrier node, bound to fsync_cc.
  Only top-level ports are visible here, so a push into a full FIFO
  is not seen and would show up as an unexplained error flag.
*/

`timescale 1ns/1ps

module fsync_cc_assert (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic [fsync_pkg::N_PORTS-1:0] local_empty_i,
  input fsync_pkg::fsync_rsp_t         local_rsp_i [fsync_pkg::N_PORTS],
  input logic [fsync_pkg::N_PORTS-1:0] local_pop_i,
  input logic [fsync_pkg::N_PORTS-1:0] remote_empty_i,
  input logic [fsync_pkg::N_PORTS-1:0] remote_pop_i,
  input logic [fsync_pkg::N_PORTS-1:0] detected_error_i
);

  logic [fsync_pkg::N_PORTS-1:0] misuse_seen_q;  // Some pop has hit an empty FIFO.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) misuse_seen_q <= '0;
    else         misuse_seen_q <= misuse_seen_q | (local_pop_i & local_empty_i)
                                                | (remote_pop_i & remote_empty_i);
  end

  for (genvar i = 0; i < fsync_pkg::N_PORTS; i++) begin : gen_port
    error_has_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
      detected_error_i[i] |-> misuse_seen_q[i])
      else $error("detected_error_o[%0d] high without FIFO misuse", i);

    error_is_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
      detected_error_i[i] |=> detected_error_i[i])
      else $error("detected_error_o[%0d] dropped before reset", i);

    head_has_wake: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !local_empty_i[i] |-> local_rsp_i[i].wake)
      else $error("local_rsp_o[%0d] head without wake", i);
  end

endmodule

bind fsync_cc fsync_cc_assert u_assert (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .local_empty_i    (local_empty_o),
  .local_rsp_i      (local_rsp_o),
  .local_pop_i      (local_pop_i),
  .remote_empty_i   (remote_empty_o),
  .remote_pop_i     (remote_pop_i),
  .detected_error_i (detected_error_o)
);

// ==== verif/tb_fsync_cc.sv ====
/*
  Testbench for the barrier node control core.
  Inputs change on the falling clock edge. Every FIFO head is popped
  and compared with a reference model of both banks. The run stops at
  the first mismatch.
*/

`timescale 1ns/1ps

module tb_fsync_cc;

  localparam int unsigned NREGS    = 4;
  localparam int unsigned NP       = fsync_pkg::N_PORTS;
  localparam int unsigned AW       = fsync_pkg::AGGR_W;
  localparam int unsigned IW       = fsync_pkg::ID_W;
  localparam int unsigned SW       = fsync_pkg::SRC_W;
  localparam int unsigned N_RANDOM = 200;
  localparam int unsigned TIMEOUT  = 50;  // Cycles per wait loop.

  logic                  clk_i;
  logic                  rst_ni;
  fsync_pkg::fsync_req_t req        [NP];
  fsync_pkg::fsync_rsp_t local_rsp  [NP];
  fsync_pkg::fsync_fwd_t remote_req [NP];
  logic [NP-1:0]         local_flag, root_flag;
  logic [NP-1:0]         local_empty, remote_empty, detected_error;
  logic [NP-1:0]         auto_local_pop  = '0;
  logic [NP-1:0]         auto_remote_pop = '0;
  logic [NP-1:0]         stray_pop;

  // Reference state with bank 0 local and bank 1 remote.
  logic                  m_valid [2][NREGS];
  logic [IW-1:0]         m_id    [2][NREGS];
  fsync_pkg::fsync_rsp_t rsp_exp [NP][$];
  fsync_pkg::fsync_fwd_t fwd_exp [NP][$];
  int unsigned           n_checked;
  int unsigned           lcg_state;
  string                 test_name;

  fsync_cc #(.N_LOCAL_REGS(NREGS), .FIFO_DEPTH_L(2), .FIFO_DEPTH_R(2)) u_dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req),
    .local_i          (local_flag),
    .root_i           (root_flag),
    .local_empty_o    (local_empty),
    .local_rsp_o      (local_rsp),
    .local_pop_i      (auto_local_pop | stray_pop),
    .remote_empty_o   (remote_empty),
    .remote_req_o     (remote_req),
    .remote_pop_i     (auto_remote_pop),
    .detected_error_o (detected_error)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;  // 4 ns period.

  // ####################
  // Reference model
  // ####################

  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic fsync_pkg::fsync_rsp_t make_rsp(logic [SW-1:0] dst, logic err);
    fsync_pkg::fsync_rsp_t r;
    r.wake  = 1'b1;
    r.dst   = dst;
    r.error = err;
    return r;
  endfunction

  function automatic fsync_pkg::fsync_fwd_t make_fwd(logic [AW-1:0] aggr, logic [IW-1:0] id,
                                                     logic [SW-1:0] src);
    fsync_pkg::fsync_fwd_t f;
    f.sync = 1'b1;
    f.aggr = aggr >> 1;  // One level up.
    f.id   = id;
    f.src  = {src, fsync_pkg::SD_MASK};
    return f;
  endfunction

  function automatic void model_reset();
    for (int b = 0; b < 2; b++) begin
      for (int e = 0; e < NREGS; e++) m_valid[b][e] = 1'b0;
    end
  endfunction

  // Expected output of one accepted request; port 0 must be called first.
  function automatic void model_request(int p, logic root, fsync_pkg::fsync_req_t r);
    int  lvl;
    int  bank;
    logic present;
    logic err;
    lvl     = 0;
    bank    = root ? 0 : 1;
    present = 1'b0;
    err     = 1'b0;
    for (int j = 0; j < AW; j++) begin
      if (r.aggr[j]) lvl = j;
    end
    if (lvl >= NREGS) begin
      err = 1'b1;
    end else if (!m_valid[bank][lvl]) begin
      m_valid[bank][lvl] = 1'b1;
      m_id[bank][lvl]    = r.id;
    end else if (m_id[bank][lvl] == r.id) begin
      m_valid[bank][lvl] = 1'b0;
      present            = 1'b1;
    end else begin
      err = 1'b1;
    end
    if (err || (root && present)) rsp_exp[p].push_back(make_rsp(r.src, err));
    else if (present)              fwd_exp[p].push_back(make_fwd(r.aggr, r.id, r.src));
  endfunction

  // ####################
  // Checks
  // ####################

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_rsp(string what, fsync_pkg::fsync_rsp_t exp,
                           fsync_pkg::fsync_rsp_t act);
    if (exp !== act) begin
      stop_on_error($sformatf("[ERROR] %s, %s: expected %h, actual %h",
                              test_name, what, exp, act));
    end
  endtask

  task automatic check_fwd(string what, fsync_pkg::fsync_fwd_t exp,
                           fsync_pkg::fsync_fwd_t act);
    if (exp !== act) begin
      stop_on_error($sformatf("[ERROR] %s, %s: expected %h, actual %h",
                              test_name, what, exp, act));
    end
  endtask

  task automatic check_bit(string what, logic exp, logic act);
    if (exp !== act) begin
      stop_on_error($sformatf("[ERROR] %s, %s: expected %b, actual %b",
                              test_name, what, exp, act));
    end
  endtask

  // Pops every head as soon as it shows up.
  always @(negedge clk_i) begin
    for (int p = 0; p < NP; p++) begin
      auto_local_pop[p]  = 1'b0;
      auto_remote_pop[p] = 1'b0;
      if (rst_ni && !local_empty[p]) begin
        if (rsp_exp[p].size() == 0) begin
          stop_on_error($sformatf("Unexpected word in local FIFO of port %0d", p));
        end else begin
          check_rsp($sformatf("local_rsp_o[%0d]", p), rsp_exp[p].pop_front(), local_rsp[p]);
          auto_local_pop[p] = 1'b1;
          n_checked++;
        end
      end
      if (rst_ni && !remote_empty[p]) begin
        if (fwd_exp[p].size() == 0) begin
          stop_on_error($sformatf("Unexpected word in remote FIFO of port %0d", p));
        end else begin
          check_fwd($sformatf("remote_req_o[%0d]", p), fwd_exp[p].pop_front(), remote_req[p]);
          auto_remote_pop[p] = 1'b1;
          n_checked++;
        end
      end
    end
  end

  // ####################
  // Stimulus
  // ####################

  task automatic drive_req(int p, logic root, logic loc, logic [AW-1:0] aggr,
                           logic [IW-1:0] id, logic [SW-1:0] src);
    req[p].sync   = 1'b1;
    req[p].aggr   = aggr;
    req[p].id     = id;
    req[p].src    = src;
    root_flag[p]  = root;
    local_flag[p] = loc;
    if (root | loc) model_request(p, root, req[p]);  // Port is idle by spacing.
  endtask

  task automatic clear_reqs();
    for (int p = 0; p < NP; p++) req[p] = '0;
    root_flag  = '0;
    local_flag = '0;
  endtask

  task automatic send_req(int p, logic root, logic loc, logic [AW-1:0] aggr,
                          logic [IW-1:0] id, logic [SW-1:0] src);
    drive_req(p, root, loc, aggr, id, src);
    @(negedge clk_i);
    clear_reqs();
    @(negedge clk_i);
  endtask

  task automatic wait_fifo(logic remote, int p);
    int unsigned n;
    n = 0;
    while ((remote ? remote_empty[p] : local_empty[p]) && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (remote ? remote_empty[p] : local_empty[p]) begin
      stop_on_error($sformatf("Timeout in %s waiting for a word on port %0d", test_name, p));
    end
  endtask

  function automatic logic outputs_idle();
    logic idle;
    idle = (local_empty == '1) && (remote_empty == '1);
    for (int p = 0; p < NP; p++) begin
      if (rsp_exp[p].size() != 0 || fwd_exp[p].size() != 0) idle = 1'b0;
    end
    return idle;
  endfunction

  task automatic drain();
    int unsigned n;
    n = 0;
    repeat (2) @(negedge clk_i);
    while (!outputs_idle() && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (!outputs_idle()) begin
      stop_on_error($sformatf("Timeout in %s: expected words never came out", test_name));
    end
  endtask

  task automatic apply_reset();
    rst_ni    = 1'b0;
    stray_pop = '0;
    clear_reqs();
    repeat (4) @(negedge clk_i);
    model_reset();
    rst_ni = 1'b1;
  endtask

  // Both ports may fire in the same cycle; each port every two cycles.
  task automatic random_traffic();
    int unsigned   sent;
    int unsigned   sel;
    int unsigned   lvl;
    int unsigned   r;
    logic [AW-1:0] aggr;
    sent = 0;
    while (sent < N_RANDOM) begin
      for (int p = 0; p < NP; p++) begin
        sel = next_random() % 5;  // 0 none, 1 no flag, 2 local, 3 root, 4 both.
        if (sel != 0 && sent < N_RANDOM) begin
          lvl  = next_random() % 6;
          r    = next_random();
          aggr = AW'((1 << lvl) | (r & ((1 << lvl) - 1)));
          drive_req(p, sel >= 3, sel == 2 || sel == 4, aggr,
                    IW'(next_random() % 2), SW'(next_random()));
          sent++;
        end
      end
      @(negedge clk_i);
      clear_reqs();
      @(negedge clk_i);
    end
  endtask

  initial begin
    rst_ni    = 1'b0;
    stray_pop = '0;
    lcg_state = 48;
    n_checked = 0;
    test_name = "reset";
    clear_reqs();
    model_reset();
    apply_reset();

    test_name = "root barrier";
    send_req(0, 1'b1, 1'b0, 8'h08, 4'd7, 4'd2);
    drive_req(1, 1'b1, 1'b0, 8'h0c, 4'd7, 4'd9);
    @(negedge clk_i);
    clear_reqs();
    check_bit("local_empty_o[1] one cycle after strobe", 1'b1, local_empty[1]);
    @(negedge clk_i);
    check_bit("local_empty_o[1] two cycles after strobe", 1'b0, local_empty[1]);
    check_rsp("wake response", make_rsp(4'd9, 1'b0), local_rsp[1]);
    check_bit("local_empty_o[0]", 1'b1, local_empty[0]);
    drain();

    test_name = "aggregation";
    send_req(0, 1'b0, 1'b1, 8'h04, 4'd5, 4'd1);
    send_req(1, 1'b0, 1'b1, 8'h05, 4'd5, 4'd2);
    wait_fifo(1'b1, 1);
    check_fwd("forwarded request", make_fwd(8'h05, 4'd5, 4'd2), remote_req[1]);
    drain();

    test_name = "errors";
    send_req(0, 1'b1, 1'b0, 8'h02, 4'd1, 4'd3);
    send_req(1, 1'b1, 1'b0, 8'h03, 4'd2, 4'd5);  // Different id.
    wait_fifo(1'b0, 1);
    check_rsp("id error response", make_rsp(4'd5, 1'b1), local_rsp[1]);
    send_req(0, 1'b0, 1'b1, 8'h41, 4'd3, 4'd4);  // Level 6.
    wait_fifo(1'b0, 0);
    check_rsp("level error response", make_rsp(4'd4, 1'b1), local_rsp[0]);
    check_bit("remote_empty_o[0]", 1'b1, remote_empty[0]);
    send_req(0, 1'b0, 1'b1, 8'h01, 4'd6, 4'd7);
    send_req(1, 1'b0, 1'b1, 8'h01, 4'd8, 4'd8);
    check_bit("remote_empty_o[1]", 1'b1, remote_empty[1]);
    drain();

    test_name = "fifo misuse";
    stray_pop[0] = 1'b1;  // Local FIFO 0 is empty here.
    @(negedge clk_i);
    stray_pop[0] = 1'b0;
    @(negedge clk_i);
    check_bit("detected_error_o[0]", 1'b1, detected_error[0]);
    repeat (6) @(negedge clk_i);
    check_bit("detected_error_o[0] held", 1'b1, detected_error[0]);
    check_bit("detected_error_o[1]", 1'b0, detected_error[1]);
    apply_reset();
    check_bit("detected_error_o[0] after reset", 1'b0, detected_error[0]);

    test_name = "random traffic";
    random_traffic();
    drain();

    if (n_checked > 0 && outputs_idle()) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Testbench failed");
      $fatal(1, "No output word was compared, or expected words remain unmatched");
    end
  end

endmodule

// ==== verilog.f ====
design/fsync_pkg.sv
design/fsync_fifo.sv
design/fsync_barrier_rf.sv
design/fsync_port_ctrl.sv
design/fsync_port.sv
design/fsync_cc.sv
verif/fsync_cc_assert.sv
verif/tb_fsync_cc.sv

// ==== Makefile ====
# Verilator build and run of the barrier node testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_fsync_cc
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with Verilator, run it, log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Testbench passed" $(LOG) && ! grep -q "%Error" $(LOG) \
		|| (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
